//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
# a $fatal in the testbench gives a nonzero exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 \
    --top-module sample_history_tb \
    -f sources.f \
    -o sample_history_sim
./obj_dir/sample_history_sim

//--- source/checkpoint_sequencer.sv
`timescale 1ns/1ps

module checkpoint_sequencer
    import history_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cmd_valid,
    input  logic        cmd_restore,
    input  page_t       cmd_page,
    output logic        busy,
    output logic        done,
    output logic        hold,
    output ring_index_t ring_addr,
    input  sample_t     ring_rdata,
    output logic        ring_we,
    output sample_t     ring_wdata,
    output logic        ring_index_load,
    output ring_index_t ring_index_set,
    input  ring_index_t ring_index,
    output logic        bank_we,
    output page_t       bank_page,
    output ring_index_t bank_addr,
    output sample_t     bank_wdata,
    output ring_index_t bank_index_wr,
    output page_t       bank_rd_page,
    output ring_index_t bank_rd_addr,
    input  sample_t     bank_rdata,
    input  ring_index_t bank_index_rd
);

    localparam int step_w = $bits(ring_index_t) + 1;
    localparam logic [step_w-1:0] restore_last = step_w'(ring_depth);

    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_save    = 2'd1;
    localparam logic [1:0] st_restore = 2'd2;

    logic [1:0]        state;
    logic [step_w-1:0] step;
    page_t             page_q;
    logic              cmd_accept;
    logic              saving;
    logic              restoring;
    ring_index_t       step_addr;
    ring_index_t       lag_addr;

    assign cmd_accept = cmd_valid && (state == st_idle);
    assign saving     = (state == st_save);
    assign restoring  = (state == st_restore);
    assign step_addr  = ring_index_t'(step);
    assign lag_addr   = ring_index_t'(step - 1'b1);   // address of the read in flight

    assign busy = (state != st_idle);
    assign hold = busy;                               // stream frozen during a copy

    // ring copy port
    assign ring_addr       = restoring ? lag_addr : step_addr;
    assign ring_we         = restoring && (step != '0);
    assign ring_wdata      = bank_rdata;
    assign ring_index_load = restoring && (step == restore_last);
    assign ring_index_set  = bank_index_rd;

    // bank ports
    assign bank_we       = saving;
    assign bank_page     = page_q;
    assign bank_addr     = step_addr;
    assign bank_wdata    = ring_rdata;
    assign bank_index_wr = ring_index;
    assign bank_rd_page  = page_q;
    assign bank_rd_addr  = step_addr;

    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            page_q <= cmd_page;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            step  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    step <= '0;
                    if (cmd_accept) begin
                        case (cmd_restore)
                            cmd_kind_save:    state <= st_save;
                            cmd_kind_restore: state <= st_restore;
                            default:          state <= st_idle;
                        endcase
                    end
                end
                st_save: begin
                    step <= step + 1'b1;
                    if (step_addr == last_index) begin
                        state <= st_idle;     // index stored with this entry
                        done  <= 1'b1;
                    end
                end
                st_restore: begin
                    step <= step + 1'b1;
                    if (step == restore_last) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- source/delay_ring.sv
`timescale 1ns/1ps

module delay_ring
    import history_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        accept,
    input  sample_t     in_data,
    output logic        out_valid,
    output sample_t     out_data,
    input  ring_index_t copy_addr,
    output sample_t     copy_rdata,
    input  logic        copy_we,
    input  sample_t     copy_wdata,
    input  logic        index_load,
    input  ring_index_t index_in,
    output ring_index_t index_out
);

    sample_t     entries [ring_depth];
    ring_index_t wr_index;

    assign copy_rdata = entries[copy_addr];     // combinational copy read
    assign index_out  = wr_index;

    // entry array, filled with a ramp on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ring_depth; i++) begin
                entries[i] <= reset_fill_base + sample_t'(i);
            end
        end else if (copy_we) begin
            entries[copy_addr] <= copy_wdata;
        end else if (accept) begin
            entries[wr_index] <= in_data;        // replaces the oldest byte
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_data <= entries[wr_index];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_index  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
            if (index_load) begin
                wr_index <= index_in;            // restored write position
            end else if (accept) begin
                wr_index <= wr_index + 1'b1;     // wraps after 127
            end
        end
    end

endmodule

//--- source/history_pkg.sv
package history_pkg;

    // one stream byte
    typedef logic [7:0] sample_t;

    // delay ring geometry
    localparam int ring_depth = 128;
    typedef logic [6:0] ring_index_t;
    localparam ring_index_t last_index = ring_index_t'(ring_depth - 1);

    // snapshot pages
    localparam int page_count = 8;
    typedef logic [2:0] page_t;

    // input FIFO slots, also the credits held after reset
    localparam int credit_count = 4;
    typedef logic [2:0] credit_t;

    // entry i comes out of reset as base + i
    localparam sample_t reset_fill_base = 8'd32;

    // cmd_restore encoding
    localparam logic cmd_kind_save    = 1'b0;
    localparam logic cmd_kind_restore = 1'b1;

endpackage

//--- source/sample_credit_fifo.sv
`timescale 1ns/1ps

module sample_credit_fifo
    import history_pkg::*;
#(
    parameter int FIFO_DEPTH = credit_count
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    input  sample_t in_data,
    output logic    fifo_valid,
    output sample_t fifo_data,
    input  logic    pop,
    output logic    credit_return
);

    localparam int ptr_w   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int count_w = $clog2(FIFO_DEPTH + 1);
    localparam logic [count_w-1:0] full_count = count_w'(FIFO_DEPTH);
    localparam logic [ptr_w-1:0]   last_slot  = ptr_w'(FIFO_DEPTH - 1);

    sample_t            slots [FIFO_DEPTH];
    logic [ptr_w-1:0]   rd_ptr;
    logic [ptr_w-1:0]   wr_ptr;
    logic [count_w-1:0] count;
    logic               push_fire;
    logic               pop_fire;

    assign fifo_valid = (count != '0);
    assign fifo_data  = slots[rd_ptr];             // show-ahead read
    assign push_fire  = in_valid && (count != full_count);
    assign pop_fire   = pop && fifo_valid;

    always_ff @(posedge clk) begin
        if (push_fire) begin
            slots[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr        <= '0;
            wr_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop_fire;             // one credit per released byte

            if (push_fire) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end

            if (pop_fire) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end

            case ({push_fire, pop_fire})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;                // idle or push and pop together
                end
            endcase
        end
    end

endmodule

//--- source/sample_history_top.sv
`timescale 1ns/1ps

module sample_history_top
    import history_pkg::*;
#(
    parameter int FIFO_DEPTH = credit_count
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    input  sample_t in_data,
    output logic    credit_return,
    output logic    out_valid,
    output sample_t out_data,
    input  logic    cmd_valid,
    input  logic    cmd_restore,
    input  page_t   cmd_page,
    output logic    busy,
    output logic    done
);

    logic        fifo_valid;
    sample_t     fifo_data;
    logic        ring_accept;
    logic        hold;
    ring_index_t ring_addr;
    sample_t     ring_rdata;
    logic        ring_we;
    sample_t     ring_wdata;
    logic        ring_index_load;
    ring_index_t ring_index_set;
    ring_index_t ring_index;
    logic        bank_we;
    page_t       bank_page;
    ring_index_t bank_addr;
    sample_t     bank_wdata;
    ring_index_t bank_index_wr;
    page_t       bank_rd_page;
    ring_index_t bank_rd_addr;
    sample_t     bank_rdata;
    ring_index_t bank_index_rd;

    assign ring_accept = fifo_valid && !hold;

    sample_credit_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_inst (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .fifo_valid    (fifo_valid),
        .fifo_data     (fifo_data),
        .pop           (ring_accept),
        .credit_return (credit_return)
    );

    delay_ring ring_inst (
        .clk        (clk),
        .reset      (reset),
        .accept     (ring_accept),
        .in_data    (fifo_data),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .copy_addr  (ring_addr),
        .copy_rdata (ring_rdata),
        .copy_we    (ring_we),
        .copy_wdata (ring_wdata),
        .index_load (ring_index_load),
        .index_in   (ring_index_set),
        .index_out  (ring_index)
    );

    snapshot_bank bank_inst (
        .clk      (clk),
        .wr_en    (bank_we),
        .wr_page  (bank_page),
        .wr_addr  (bank_addr),
        .wr_data  (bank_wdata),
        .rd_page  (bank_rd_page),
        .rd_addr  (bank_rd_addr),
        .rd_data  (bank_rdata),
        .index_wr (bank_index_wr),
        .index_rd (bank_index_rd)
    );

    checkpoint_sequencer seq_inst (
        .clk             (clk),
        .reset           (reset),
        .cmd_valid       (cmd_valid),
        .cmd_restore     (cmd_restore),
        .cmd_page        (cmd_page),
        .busy            (busy),
        .done            (done),
        .hold            (hold),
        .ring_addr       (ring_addr),
        .ring_rdata      (ring_rdata),
        .ring_we         (ring_we),
        .ring_wdata      (ring_wdata),
        .ring_index_load (ring_index_load),
        .ring_index_set  (ring_index_set),
        .ring_index      (ring_index),
        .bank_we         (bank_we),
        .bank_page       (bank_page),
        .bank_addr       (bank_addr),
        .bank_wdata      (bank_wdata),
        .bank_index_wr   (bank_index_wr),
        .bank_rd_page    (bank_rd_page),
        .bank_rd_addr    (bank_rd_addr),
        .bank_rdata      (bank_rdata),
        .bank_index_rd   (bank_index_rd)
    );

endmodule

//--- source/snapshot_bank.sv
`timescale 1ns/1ps

module snapshot_bank
    import history_pkg::*;
(
    input  logic        clk,
    input  logic        wr_en,
    input  page_t       wr_page,
    input  ring_index_t wr_addr,
    input  sample_t     wr_data,
    input  page_t       rd_page,
    input  ring_index_t rd_addr,
    output sample_t     rd_data,
    input  ring_index_t index_wr,
    output ring_index_t index_rd
);

    sample_t     pages [page_count * ring_depth];   // page-major
    ring_index_t saved_index [page_count];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            pages[{wr_page, wr_addr}] <= wr_data;
        end
        // write position goes in with the last entry
        if (wr_en && (wr_addr == last_index)) begin
            saved_index[wr_page] <= index_wr;
        end
    end

    always_ff @(posedge clk) begin
        rd_data  <= pages[{rd_page, rd_addr}];     // one cycle latency
        index_rd <= saved_index[rd_page];
    end

endmodule

//--- sources.f
source/history_pkg.sv
source/sample_credit_fifo.sv
source/delay_ring.sv
source/snapshot_bank.sv
source/checkpoint_sequencer.sv
source/sample_history_top.sv
tests/sample_history_tb.sv

//--- tests/sample_history_tb.sv
`timescale 1ns/1ps

module sample_history_tb
    import history_pkg::*;
();

    localparam int fifo_depth = credit_count;
    localparam int log_depth  = 2048;

    logic    clk = 1'b0;
    logic    reset;
    logic    in_valid;
    sample_t in_data;
    logic    cmd_valid;
    logic    cmd_restore;
    page_t   cmd_page;
    logic    credit_return;
    logic    out_valid;
    sample_t out_data;
    logic    busy;
    logic    done;

    sample_t     push_log [log_depth];            // every byte in push order
    int          pushes_sent;
    int          returns_seen;
    int          outputs_seen;
    sample_t     model_ring [ring_depth];
    ring_index_t model_idx;
    sample_t     model_pages [page_count][ring_depth];
    ring_index_t model_page_idx [page_count];
    logic        pending_restore;
    page_t       pending_page;

    sample_history_top #(
        .FIFO_DEPTH (fifo_depth)
    ) sample_history_top_inst (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .cmd_valid     (cmd_valid),
        .cmd_restore   (cmd_restore),
        .cmd_page      (cmd_page),
        .busy          (busy),
        .done          (done)
    );

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic fail_run(input string what);
        $display("ERROR at %0t: %s", $time, what);
        stop_run();
    endtask

    task automatic check_sample(input sample_t actual, input sample_t expected, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_credits(input credit_t actual, input credit_t expected, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, what, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, what, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("FAILED at %0t: %s took %0d cycles expected %0d", $time, what, actual,
                     expected);
            stop_run();
        end
    endtask

    function automatic credit_t credits_held();
        return credit_t'(fifo_depth - pushes_sent + returns_seen);
    endfunction

    // reference model, sampled on the falling edge where outputs are stable
    always @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < ring_depth; i++) begin
                model_ring[i] = sample_t'(32 + i);   // ramp 32 through 159
            end
            model_idx    = '0;
            returns_seen = 0;
            outputs_seen = 0;
        end else begin
            check_flag(credit_return, out_valid, "credit_return against out_valid");
            if (credit_return) begin
                returns_seen++;
            end
            if (returns_seen > pushes_sent) begin
                fail_run("a credit came back with no push outstanding");
            end
            if (out_valid) begin
                if (outputs_seen >= pushes_sent) begin
                    fail_run("out_valid pulsed with no byte left in the unit");
                end
                check_sample(out_data, model_ring[model_idx], "displaced ring byte");
                model_ring[model_idx] = push_log[outputs_seen];
                model_idx = model_idx + 1'b1;
                outputs_seen++;
            end
            if (done) begin
                for (int i = 0; i < ring_depth; i++) begin
                    if (pending_restore) begin
                        model_ring[i] = model_pages[pending_page][i];
                    end else begin
                        model_pages[pending_page][i] = model_ring[i];
                    end
                end
                if (pending_restore) begin
                    model_idx = model_page_idx[pending_page];
                end else begin
                    model_page_idx[pending_page] = model_idx;
                end
            end
        end
    end

    task automatic push_byte(input sample_t value);
        int waited;
        waited = 0;
        while (credits_held() == '0) begin
            in_valid <= 1'b0;
            @(posedge clk);
            waited++;
            if (waited > 300) begin
                fail_run("timed out waiting for a credit return");
            end
        end
        push_log[pushes_sent] = value;
        pushes_sent++;
        in_valid <= 1'b1;
        in_data  <= value;
        @(posedge clk);
    endtask

    task automatic stream_random(input int count);
        for (int i = 0; i < count; i++) begin
            push_byte(sample_t'($urandom()));
        end
        in_valid <= 1'b0;
    endtask

    task automatic drain_and_count();
        int waited;
        waited = 0;
        while (outputs_seen != pushes_sent) begin
            @(posedge clk);
            waited++;
            if (waited > 100) begin
                fail_run("timed out waiting for the ring to take every pushed byte");
            end
        end
        check_credits(credits_held(), credit_t'(fifo_depth), "credits held after drain");
    endtask

    task automatic issue_cmd(input logic restore, input page_t page);
        pending_restore = restore;
        pending_page    = page;
        cmd_valid   <= 1'b1;
        cmd_restore <= restore;
        cmd_page    <= page;
        @(posedge clk);                           // accepted on this edge
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_done(input int expected, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            check_flag(busy, cycles < expected, "busy during a copy");
            // a byte taken on the accept edge may still show in the first cycle
            if (cycles > 1) begin
                check_flag(out_valid, 1'b0, "out_valid while the stream is held");
            end
            if (cycles > 200) begin
                fail_run({"timed out waiting for done after ", what});
            end
        end while (!done);
        check_count(cycles, expected, what);
        @(posedge clk);
    endtask

    task automatic run_command(input logic restore, input page_t page, input string what);
        issue_cmd(restore, page);
        wait_done(restore ? 130 : 129, what);
    endtask

    task automatic fill_from_reset();
        int cycles;
        cycles = 0;
        push_byte(sample_t'($urandom()));
        in_valid <= 1'b0;
        // FIFO push edge, ring accept edge, then the strobe
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                fail_run("timed out waiting for the first out_valid");
            end
        end while (!out_valid);
        check_count(cycles, 2, "first byte to out_valid");
        @(posedge clk);
        stream_random(127);
        drain_and_count();
    endtask

    task automatic save_while_streaming();
        issue_cmd(cmd_kind_save, 3'd3);
        cmd_valid   <= 1'b1;                      // offered while busy
        cmd_restore <= cmd_kind_save;
        cmd_page    <= 3'd6;
        fork
            wait_done(129, "save to page 3");
            begin
                @(posedge clk);
                cmd_valid <= 1'b0;
                stream_random(6);                 // four fit, the rest wait for credits
            end
        join
        drain_and_count();
    endtask

    task automatic restore_pages();
        run_command(cmd_kind_save, 3'd1, "save to page 1");
        stream_random(50);
        run_command(cmd_kind_save, 3'd5, "save to page 5");
        stream_random(70);
        run_command(cmd_kind_restore, 3'd1, "restore of page 1");
        stream_random(200);
        run_command(cmd_kind_restore, 3'd5, "restore of page 5");
        stream_random(200);
        run_command(cmd_kind_restore, 3'd3, "restore of page 3");
        stream_random(150);
        drain_and_count();
    endtask

    initial begin
        void'($urandom(32'h2680));
        pushes_sent = 0;
        reset       <= 1'b1;
        in_valid    <= 1'b0;
        in_data     <= '0;
        cmd_valid   <= 1'b0;
        cmd_restore <= 1'b0;
        cmd_page    <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        fill_from_reset();
        stream_random(300);
        drain_and_count();
        save_while_streaming();
        restore_pages();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
